// ==== logic/tlp_pkg.sv ====
`default_nettype none

package tlp_pkg;

	// ------------------------------------------------------------
	// Request class, decoded from the type field of header word 0
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		// Memory read or write, direction comes from fmt[1]
		KIND_MEM_RD    = 3'h0,
		KIND_MEM_RD_LK = 3'h1,
		KIND_IO        = 3'h2,
		KIND_CFG0      = 3'h3,
		KIND_CFG1      = 3'h4,
		KIND_MSG       = 3'h5,
		KIND_CPL       = 3'h6,
		KIND_CPL_LK    = 3'h7
	} tlp_kind_e;

	// Width of the slave bus halfword address field
	localparam int SLV_ADR_BUS_W = 19;

	// Completion with data, fixed header fields
	localparam logic [1:0] CPL_FMT_DATA = 2'b10;
	localparam logic [4:0] CPL_TYPE = 5'b01010;
	localparam int CPL_HDR_WORDS = 6;

	// Posted data credit granularity
	localparam int CREDIT_DW_PER_UNIT = 4;

	typedef struct packed {
		logic [1:0]  fmt;
		tlp_kind_e   kind;
		logic [2:0]  tc;
		logic        td;
		logic        ep;
		logic [1:0]  attr;
		logic [9:0]  length;
		logic [15:0] req_id;
		logic [7:0]  tag;
		logic [3:0]  last_be;
		logic [3:0]  first_be;
		logic [63:2] addr;
		logic [6:0]  bar_hit;
	} tlp_hdr_t;

	typedef struct packed {
		logic        last;
		logic [15:0] data;
	} payload_t;

	typedef struct packed {
		logic       ph;
		logic       pd;
		logic       nph;
		logic       npd;
		logic [7:0] pd_num;
	} credit_t;

	typedef struct packed {
		logic [6:0]               bar;
		logic                     ce;
		logic                     we;
		logic [SLV_ADR_BUS_W-1:0] adr;
		logic [15:0]              dat;
		logic [1:0]               sel;
	} slv_req_t;

	typedef struct packed {
		logic [7:0] bus;
		logic [4:0] device;
		logic [2:0] func;
	} completer_id_t;

	typedef struct packed {
		logic [9:0]  length;
		logic [11:0] byte_count;
		logic [15:0] req_id;
		logic [7:0]  tag;
		logic [6:0]  lower_addr;
	} cpl_hdr_t;

endpackage

`default_nettype wire

// ==== logic/tlp_rx_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlp_rx_parser
	import tlp_pkg::*;
(
	input  wire        pcie_clk,
	input  wire        sys_rst,
	input  wire        rx_st_i,
	input  wire        rx_end_i,
	input  wire [15:0] rx_data_i,
	input  wire [6:0]  rx_bar_hit_i,
	output tlp_hdr_t   hdr_o,
	output logic       hdr_valid_o,
	output logic       eop_o,
	output payload_t   pld_o,
	output logic       pld_valid_o
);

	typedef enum logic [3:0] {
		RX_HEAD0,
		RX_HEAD1,
		RX_REQID,
		RX_TAG,
		RX_ADDR_HI0,
		RX_ADDR_HI1,
		RX_ADDR_LO0,
		RX_ADDR_LO1,
		RX_PAYLOAD,
		RX_DISCARD
	} rx_state_e;

	rx_state_e state;

	function automatic tlp_kind_e decode_kind(input logic [4:0] typ);
		tlp_kind_e kind;
		if (typ[4]) begin
			kind = KIND_MSG;
		end else if (typ[3]) begin
			kind = typ[0] ? KIND_CPL_LK : KIND_CPL;
		end else begin
			case (typ[2:0])
				3'b000:  kind = KIND_MEM_RD;
				3'b001:  kind = KIND_MEM_RD_LK;
				3'b010:  kind = KIND_IO;
				3'b100:  kind = KIND_CFG0;
				default: kind = KIND_CFG1;
			endcase
		end
		return kind;
	endfunction

	// ------------------------------------------------------------
	// Header walk
	// ------------------------------------------------------------
	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= RX_HEAD0;
			hdr_valid_o <= 1'b0;
			eop_o <= 1'b0;
			pld_valid_o <= 1'b0;
		end else begin
			hdr_valid_o <= (state == RX_ADDR_LO1);
			eop_o <= rx_end_i;
			pld_valid_o <= (state == RX_PAYLOAD);
			case (state)
				RX_HEAD0: begin
					if (rx_st_i)
						state <= RX_HEAD1;
				end
				RX_HEAD1: begin
					// Completions are not consumed here
					if (hdr_o.kind == KIND_CPL || hdr_o.kind == KIND_CPL_LK)
						state <= RX_DISCARD;
					else
						state <= RX_REQID;
				end
				RX_REQID:    state <= RX_TAG;
				RX_TAG:      state <= hdr_o.fmt[0] ? RX_ADDR_HI0 : RX_ADDR_LO0;
				RX_ADDR_HI0: state <= RX_ADDR_HI1;
				RX_ADDR_HI1: state <= RX_ADDR_LO0;
				RX_ADDR_LO0: state <= RX_ADDR_LO1;
				RX_ADDR_LO1: state <= RX_PAYLOAD;
				default:     state <= state;
			endcase
			if (rx_end_i && state != RX_HEAD0)
				state <= RX_HEAD0;
		end
	end

	// Field capture and payload delay
	always_ff @(posedge pcie_clk) begin
		pld_o <= '{last: rx_end_i, data: rx_data_i};
		case (state)
			RX_HEAD0: begin
				if (rx_st_i) begin
					hdr_o.fmt <= rx_data_i[14:13];
					hdr_o.kind <= decode_kind(rx_data_i[12:8]);
					hdr_o.tc <= rx_data_i[6:4];
					hdr_o.bar_hit <= rx_bar_hit_i;
				end
			end
			RX_HEAD1: begin
				hdr_o.td <= rx_data_i[15];
				hdr_o.ep <= rx_data_i[14];
				hdr_o.attr <= rx_data_i[13:12];
				hdr_o.length <= rx_data_i[9:0];
			end
			RX_REQID: hdr_o.req_id <= rx_data_i;
			RX_TAG: begin
				hdr_o.tag <= rx_data_i[15:8];
				hdr_o.last_be <= rx_data_i[7:4];
				hdr_o.first_be <= rx_data_i[3:0];
				// 3DW header, no upper address
				if (!hdr_o.fmt[0])
					hdr_o.addr[63:32] <= '0;
			end
			RX_ADDR_HI0: hdr_o.addr[63:48] <= rx_data_i;
			RX_ADDR_HI1: hdr_o.addr[47:32] <= rx_data_i;
			RX_ADDR_LO0: hdr_o.addr[31:16] <= rx_data_i;
			RX_ADDR_LO1: hdr_o.addr[15:2] <= rx_data_i[15:2];
			default: ;
		endcase
	end

	a_st_at_boundary: assert property (@(posedge pcie_clk) disable iff (sys_rst)
		rx_st_i |-> state == RX_HEAD0)
		else $error("rx_st_i seen inside a packet");

endmodule

`default_nettype wire

// ==== logic/rx_credit_release.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_credit_release
	import tlp_pkg::*;
(
	input  wire      pcie_clk,
	input  wire      sys_rst,
	input  tlp_hdr_t hdr_i,
	input  wire      eop_i,
	output credit_t  credit_o
);

	logic [10:0] len_dw;
	logic [7:0]  pd_units;
	logic        bar_hit;

	// Dwords to data credits, rounded up
	assign len_dw = {1'b0, hdr_i.length};
	assign pd_units = 8'((len_dw + 11'(CREDIT_DW_PER_UNIT - 1)) / 11'(CREDIT_DW_PER_UNIT));
	assign bar_hit = |hdr_i.bar_hit;

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			credit_o <= '0;
		end else begin
			credit_o <= '0;
			if (eop_i) begin
				case (hdr_i.kind)
					KIND_MEM_RD, KIND_MEM_RD_LK: begin
						// Memory misses release nothing
						if (bar_hit) begin
							if (hdr_i.fmt[1]) begin
								credit_o.ph <= 1'b1;
								credit_o.pd <= 1'b1;
								credit_o.pd_num <= pd_units;
							end else begin
								credit_o.nph <= 1'b1;
							end
						end
					end
					KIND_IO, KIND_CFG0, KIND_CFG1: begin
						credit_o.nph <= 1'b1;
						credit_o.npd <= hdr_i.fmt[1];
					end
					KIND_MSG: begin
						credit_o.ph <= 1'b1;
						if (hdr_i.fmt[1]) begin
							credit_o.pd <= 1'b1;
							credit_o.pd_num <= pd_units;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/slave_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module slave_sequencer
	import tlp_pkg::*;
#(
	parameter int SLV_ADDR_W = 19
) (
	input  wire      pcie_clk,
	input  wire      sys_rst,
	input  tlp_hdr_t hdr_i,
	input  wire      hdr_valid_i,
	input  payload_t pld_i,
	input  wire      pld_valid_i,
	input  wire      rd_pull_i,
	input  wire      cpl_done_i,
	output slv_req_t slv_o,
	output cpl_hdr_t cpl_o,
	output logic     cpl_valid_o
);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_WRITE,
		SEQ_READ
	} seq_state_e;

	seq_state_e state;

	logic                  mem_hit;
	logic [SLV_ADDR_W-1:0] start_adr;
	logic [SLV_ADDR_W-1:0] adr_q;
	logic [10:0]           hw_idx;
	logic [9:0]            len_q;
	logic [3:0]            first_be_q;
	logic [3:0]            last_be_q;
	logic [3:0]            cur_be;
	logic [1:0]            be_lsb;
	logic [6:0]            bar_q;
	logic                  ce_q;
	logic                  we_q;
	logic [SLV_ADDR_W-1:0] slv_adr_q;
	logic [15:0]           dat_q;
	logic [1:0]            sel_q;

	assign mem_hit = hdr_valid_i && hdr_i.kind == KIND_MEM_RD && |hdr_i.bar_hit;
	// Dword address to halfword address
	assign start_adr = {hdr_i.addr[SLV_ADDR_W:2], 1'b0};

	// Byte enables of the dword holding the current halfword
	always_comb begin
		if (hw_idx[10:1] == '0)
			cur_be = first_be_q;
		else if (hw_idx[10:1] == len_q - 10'd1)
			cur_be = last_be_q;
		else
			cur_be = 4'b1111;
	end

	// First enabled byte, low bits of the completion lower address
	always_comb begin
		casez (hdr_i.first_be)
			4'b???1: be_lsb = 2'd0;
			4'b??10: be_lsb = 2'd1;
			4'b?100: be_lsb = 2'd2;
			4'b1000: be_lsb = 2'd3;
			default: be_lsb = 2'd0;
		endcase
	end

	// ------------------------------------------------------------
	// Control
	// ------------------------------------------------------------
	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= SEQ_IDLE;
			ce_q <= 1'b0;
			we_q <= 1'b0;
			cpl_valid_o <= 1'b0;
		end else begin
			ce_q <= 1'b0;
			we_q <= 1'b0;
			cpl_valid_o <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (mem_hit) begin
						cpl_valid_o <= !hdr_i.fmt[1];
						state <= hdr_i.fmt[1] ? SEQ_WRITE : SEQ_READ;
					end
				end
				SEQ_WRITE: begin
					if (pld_valid_i) begin
						ce_q <= 1'b1;
						we_q <= 1'b1;
						if (pld_i.last)
							state <= SEQ_IDLE;
					end
				end
				SEQ_READ: begin
					ce_q <= rd_pull_i;
					if (cpl_done_i)
						state <= SEQ_IDLE;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Address, data and completion fields
	always_ff @(posedge pcie_clk) begin
		case (state)
			SEQ_IDLE: begin
				if (mem_hit) begin
					adr_q <= start_adr;
					hw_idx <= '0;
					len_q <= hdr_i.length;
					first_be_q <= hdr_i.first_be;
					last_be_q <= hdr_i.last_be;
					bar_q <= hdr_i.bar_hit;
					cpl_o <= '{
						length:     hdr_i.length,
						byte_count: {hdr_i.length, 2'b00},
						req_id:     hdr_i.req_id,
						tag:        hdr_i.tag,
						lower_addr: {hdr_i.addr[6:2], be_lsb}
					};
				end
			end
			SEQ_WRITE: begin
				if (pld_valid_i) begin
					slv_adr_q <= adr_q;
					adr_q <= adr_q + 1'b1;
					hw_idx <= hw_idx + 1'b1;
					dat_q <= pld_i.data;
					sel_q <= hw_idx[0] ? {cur_be[2], cur_be[3]} : {cur_be[0], cur_be[1]};
				end
			end
			SEQ_READ: begin
				if (rd_pull_i) begin
					slv_adr_q <= adr_q;
					adr_q <= adr_q + 1'b1;
					sel_q <= 2'b11;
				end
			end
			default: ;
		endcase
	end

	assign slv_o = '{
		bar: bar_q,
		ce:  ce_q,
		we:  we_q,
		adr: SLV_ADR_BUS_W'(slv_adr_q),
		dat: dat_q,
		sel: sel_q
	};

	a_no_write_in_read: assert property (@(posedge pcie_clk) disable iff (sys_rst)
		state == SEQ_READ |-> !we_q)
		else $error("slave write issued during a read completion");

endmodule

`default_nettype wire

// ==== logic/cpl_transmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpl_transmitter
	import tlp_pkg::*;
(
	input  wire           pcie_clk,
	input  wire           sys_rst,
	input  cpl_hdr_t      cpl_i,
	input  wire           cpl_valid_i,
	input  completer_id_t cpl_id_i,
	input  wire [15:0]    rd_data_i,
	input  wire           tx_rdy_i,
	output logic          tx_req_o,
	output logic          tx_st_o,
	output logic          tx_end_o,
	output logic [15:0]   tx_data_o,
	output logic          rd_pull_o,
	output logic          cpl_done_o
);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_WAIT,
		TX_HEADER,
		TX_DATA
	} tx_state_e;

	tx_state_e state;

	cpl_hdr_t    cpl_q;
	logic [11:0] cnt;
	logic [11:0] n_words;
	logic        last_word;
	logic [15:0] hdr_word;

	// Length 0 stands for 1024 dwords
	assign n_words = {cpl_q.length == 10'd0, cpl_q.length, 1'b0};
	assign last_word = (cnt == n_words - 12'd1);

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= TX_IDLE;
			tx_req_o <= 1'b0;
			cnt <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (cpl_valid_i) begin
						tx_req_o <= 1'b1;
						state <= TX_WAIT;
					end
				end
				TX_WAIT: begin
					if (tx_rdy_i) begin
						tx_req_o <= 1'b0;
						cnt <= '0;
						state <= TX_HEADER;
					end
				end
				TX_HEADER: begin
					if (cnt == 12'(CPL_HDR_WORDS - 1)) begin
						cnt <= '0;
						state <= TX_DATA;
					end else begin
						cnt <= cnt + 12'd1;
					end
				end
				TX_DATA: begin
					cnt <= cnt + 12'd1;
					if (last_word)
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (state == TX_IDLE && cpl_valid_i)
			cpl_q <= cpl_i;
	end

	// ------------------------------------------------------------
	// Completion header words
	// ------------------------------------------------------------
	always_comb begin
		case (cnt[2:0])
			3'd0:    hdr_word = {1'b0, CPL_FMT_DATA, CPL_TYPE, 1'b0, 3'b000, 4'b0000};
			3'd1:    hdr_word = {4'b0000, 2'b00, cpl_q.length};
			3'd2:    hdr_word = cpl_id_i;
			// Successful status, no BCM
			3'd3:    hdr_word = {3'b000, 1'b0, cpl_q.byte_count};
			3'd4:    hdr_word = cpl_q.req_id;
			3'd5:    hdr_word = {cpl_q.tag, 1'b0, cpl_q.lower_addr};
			default: hdr_word = '0;
		endcase
	end

	assign tx_st_o = (state == TX_HEADER) && (cnt == '0);
	assign tx_end_o = (state == TX_DATA) && last_word;
	assign cpl_done_o = tx_end_o;
	assign tx_data_o = (state == TX_DATA) ? rd_data_i : hdr_word;

	// Slave read data arrives two cycles after the pull
	assign rd_pull_o = ((state == TX_HEADER) && (cnt >= 12'(CPL_HDR_WORDS - 2)))
		|| ((state == TX_DATA) && (cnt + 12'd2 < n_words));

	a_start_after_grant: assert property (@(posedge pcie_clk) disable iff (sys_rst)
		tx_st_o |-> $past(tx_req_o && tx_rdy_i))
		else $error("completion started without request and ready");

endmodule

`default_nettype wire

// ==== logic/pcie_tlp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcie_tlp_top
	import tlp_pkg::*;
#(
	parameter int SLV_ADDR_W = 19
) (
	input  wire           pcie_clk,
	input  wire           sys_rst,
	input  wire [6:0]     rx_bar_hit_i,
	input  wire           rx_st_i,
	input  wire           rx_end_i,
	input  wire [15:0]    rx_data_i,
	input  completer_id_t cpl_id_i,
	input  wire           tx_rdy_i,
	output logic          tx_req_o,
	output logic          tx_st_o,
	output logic          tx_end_o,
	output logic [15:0]   tx_data_o,
	output credit_t       credit_o,
	output slv_req_t      slv_o,
	input  wire [15:0]    slv_dat_i
);

	tlp_hdr_t hdr;
	logic     hdr_valid;
	logic     eop;
	payload_t pld;
	logic     pld_valid;
	cpl_hdr_t cpl;
	logic     cpl_valid;
	logic     rd_pull;
	logic     cpl_done;

	// ------------------------------------------------------------
	// Receive path
	// ------------------------------------------------------------
	tlp_rx_parser u_parser (
		.pcie_clk     (pcie_clk),
		.sys_rst      (sys_rst),
		.rx_st_i      (rx_st_i),
		.rx_end_i     (rx_end_i),
		.rx_data_i    (rx_data_i),
		.rx_bar_hit_i (rx_bar_hit_i),
		.hdr_o        (hdr),
		.hdr_valid_o  (hdr_valid),
		.eop_o        (eop),
		.pld_o        (pld),
		.pld_valid_o  (pld_valid)
	);

	rx_credit_release u_credit (
		.pcie_clk (pcie_clk),
		.sys_rst  (sys_rst),
		.hdr_i    (hdr),
		.eop_i    (eop),
		.credit_o (credit_o)
	);

	slave_sequencer #(
		.SLV_ADDR_W (SLV_ADDR_W)
	) u_seq (
		.pcie_clk    (pcie_clk),
		.sys_rst     (sys_rst),
		.hdr_i       (hdr),
		.hdr_valid_i (hdr_valid),
		.pld_i       (pld),
		.pld_valid_i (pld_valid),
		.rd_pull_i   (rd_pull),
		.cpl_done_i  (cpl_done),
		.slv_o       (slv_o),
		.cpl_o       (cpl),
		.cpl_valid_o (cpl_valid)
	);

	// Completion path, read data comes straight from the slave bus
	cpl_transmitter u_tx (
		.pcie_clk    (pcie_clk),
		.sys_rst     (sys_rst),
		.cpl_i       (cpl),
		.cpl_valid_i (cpl_valid),
		.cpl_id_i    (cpl_id_i),
		.rd_data_i   (slv_dat_i),
		.tx_rdy_i    (tx_rdy_i),
		.tx_req_o    (tx_req_o),
		.tx_st_o     (tx_st_o),
		.tx_end_o    (tx_end_o),
		.tx_data_o   (tx_data_o),
		.rd_pull_o   (rd_pull),
		.cpl_done_o  (cpl_done)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_tlp_cases.svh ====
// Table of cases with header and payload words, BAR hit, expected credits,
// slave accesses, completion words and memory contents
task automatic fill_case_table();
	int c;
	int k;
	for (c = 0; c < N_CASES; c++) begin
		tlp_len[c] = 0;
		exp_slv_n[c] = 0;
		exp_tx_n[c] = 0;
		exp_req_n[c] = 0;
		mem_chk_n[c] = 0;
		exp_credit[c] = '0;
	end

	// Memory write with 3DW header of 3 dwords and BE first 1100 last 0011
	tlp_words[0][0:11] = '{16'h4000, 16'h0003, 16'h0100, 16'h113C, 16'h0000, 16'h0040,
		16'h0A01, 16'h0B02, 16'h0C03, 16'h0D04, 16'h0E05, 16'h0F06};
	tlp_len[0] = 12;
	tlp_bar[0] = 7'h01;
	exp_credit[0] = '{ph: 1'b1, pd: 1'b1, nph: 1'b0, npd: 1'b0, pd_num: 8'd1};
	exp_slv_n[0] = 6;
	for (k = 0; k < 6; k++) begin
		exp_slv[0][k] = '{bar: 7'h01, ce: 1'b1, we: 1'b1, adr: 19'(32'h20 + k),
			dat: tlp_words[0][6 + k], sel: (k == 0 || k == 5) ? 2'b00 : 2'b11};
	end
	mem_chk_n[0] = 6;
	mem_chk_adr[0][0:5] = '{10'h020, 10'h021, 10'h022, 10'h023, 10'h024, 10'h025};
	mem_chk_val[0][0:5] = '{16'hAC20, 16'h0B02, 16'h0C03, 16'h0D04, 16'h0E05, 16'hAC25};

	// Memory read with 4DW header of 2 dwords at byte address 0x84
	tlp_words[1][0:7] = '{16'h2000, 16'h0002, 16'h0200, 16'h22FF,
		16'h0000, 16'h0000, 16'h0000, 16'h0084};
	tlp_len[1] = 8;
	tlp_bar[1] = 7'h04;
	exp_credit[1] = '{ph: 1'b0, pd: 1'b0, nph: 1'b1, npd: 1'b0, pd_num: 8'd0};
	exp_slv_n[1] = 4;
	for (k = 0; k < 4; k++) begin
		exp_slv[1][k] = '{bar: 7'h04, ce: 1'b1, we: 1'b0, adr: 19'(32'h42 + k),
			dat: 16'h0000, sel: 2'b11};
	end
	exp_tx_n[1] = 10;
	exp_tx[1][0:5] = '{17'h04A00, 17'h00002, 17'h00321, 17'h00008, 17'h00200, 17'h02204};
	for (k = 0; k < 4; k++)
		exp_tx[1][6 + k] = {k == 3, fill_pattern(10'(32'h42 + k))};
	exp_req_n[1] = 1;

	// Same read without a BAR hit
	tlp_words[2] = tlp_words[1];
	tlp_len[2] = 8;
	tlp_bar[2] = 7'h00;

	// I/O write of 1 dword and a configuration read
	tlp_words[3][0:7] = '{16'h4200, 16'h0001, 16'h0300, 16'h330F,
		16'h0000, 16'h0010, 16'h1234, 16'h5678};
	tlp_len[3] = 8;
	tlp_bar[3] = 7'h01;
	exp_credit[3] = '{ph: 1'b0, pd: 1'b0, nph: 1'b1, npd: 1'b1, pd_num: 8'd0};
	tlp_words[4][0:5] = '{16'h0400, 16'h0001, 16'h0400, 16'h440F, 16'h0000, 16'h0010};
	tlp_len[4] = 6;
	tlp_bar[4] = 7'h00;
	exp_credit[4] = '{ph: 1'b0, pd: 1'b0, nph: 1'b1, npd: 1'b0, pd_num: 8'd0};

	// Message with 5 dwords of data
	tlp_words[5][0:7] = '{16'h7000, 16'h0005, 16'h0500, 16'h5500,
		16'h0000, 16'h0000, 16'h0000, 16'h0000};
	for (k = 0; k < 10; k++)
		tlp_words[5][8 + k] = 16'(32'h6000 + k);
	tlp_len[5] = 18;
	tlp_bar[5] = 7'h00;
	exp_credit[5] = '{ph: 1'b1, pd: 1'b1, nph: 1'b0, npd: 1'b0, pd_num: 8'd2};
endtask

// ==== testbench/tb_pcie_tlp.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_tlp
	import tlp_pkg::*;
;

	localparam int N_CASES = 6;
	localparam int MAX_W = 20;

	logic          pcie_clk = 1'b0;
	logic          sys_rst;
	logic [6:0]    rx_bar_hit_i;
	logic          rx_st_i;
	logic          rx_end_i;
	logic [15:0]   rx_data_i;
	completer_id_t cpl_id_i;
	logic          tx_rdy_i;
	logic          tx_req_o;
	logic          tx_st_o;
	logic          tx_end_o;
	logic [15:0]   tx_data_o;
	credit_t       credit_o;
	slv_req_t      slv_o;
	logic [15:0]   slv_dat_i;

	logic [15:0] tlp_words [N_CASES][MAX_W];
	int          tlp_len [N_CASES];
	logic [6:0]  tlp_bar [N_CASES];
	credit_t     exp_credit [N_CASES];
	slv_req_t    exp_slv [N_CASES][8];
	int          exp_slv_n [N_CASES];
	logic [16:0] exp_tx [N_CASES][10];
	int          exp_tx_n [N_CASES];
	int          exp_req_n [N_CASES];
	logic [9:0]  mem_chk_adr [N_CASES][6];
	logic [15:0] mem_chk_val [N_CASES][6];
	int          mem_chk_n [N_CASES];

	logic [15:0] slv_mem [1024];
	credit_t     cr_q [$];
	slv_req_t    slv_q [$];
	logic [16:0] tx_q [$];
	int          req_cnt;
	logic        req_prev;
	logic        capturing;
	int          errors = 0;
	int          timeouts = 0;
	integer      seed = 32'h6f00;

	pcie_tlp_top #(
		.SLV_ADDR_W (19)
	) dut_i (
		.pcie_clk     (pcie_clk),
		.sys_rst      (sys_rst),
		.rx_bar_hit_i (rx_bar_hit_i),
		.rx_st_i      (rx_st_i),
		.rx_end_i     (rx_end_i),
		.rx_data_i    (rx_data_i),
		.cpl_id_i     (cpl_id_i),
		.tx_rdy_i     (tx_rdy_i),
		.tx_req_o     (tx_req_o),
		.tx_st_o      (tx_st_o),
		.tx_end_o     (tx_end_o),
		.tx_data_o    (tx_data_o),
		.credit_o     (credit_o),
		.slv_o        (slv_o),
		.slv_dat_i    (slv_dat_i)
	);

	always #2 pcie_clk = ~pcie_clk;

	function automatic logic [15:0] fill_pattern(input logic [9:0] adr);
		return {6'b101011, adr};
	endfunction

	`include "tb_tlp_cases.svh"

	// ------------------------------------------------------------
	// Slave memory, byte lanes under sel
	// ------------------------------------------------------------
	always @(posedge pcie_clk) begin
		if (slv_o.ce === 1'b1) begin
			if (slv_o.we) begin
				if (slv_o.sel[1])
					slv_mem[slv_o.adr[9:0]][15:8] <= slv_o.dat[15:8];
				if (slv_o.sel[0])
					slv_mem[slv_o.adr[9:0]][7:0] <= slv_o.dat[7:0];
			end else begin
				slv_dat_i <= slv_mem[slv_o.adr[9:0]];
			end
		end
	end

	// Output monitor
	always @(negedge pcie_clk) begin
		if (sys_rst) begin
			req_prev = 1'b0;
			capturing = 1'b0;
		end else begin
			if (credit_o !== '0)
				cr_q.push_back(credit_o);
			if (slv_o.ce === 1'b1)
				slv_q.push_back(slv_o);
			if (tx_st_o === 1'b1) begin
				if (!(req_prev && tx_rdy_i)) begin
					$display("completion started at %0t without request and ready", $time);
					errors++;
				end
				capturing = 1'b1;
			end
			if (capturing) begin
				tx_q.push_back({tx_end_o, tx_data_o});
				if (tx_end_o)
					capturing = 1'b0;
			end
			if (tx_req_o && !req_prev)
				req_cnt++;
			req_prev = tx_req_o;
		end
	end

	task automatic compare_credit(input credit_t got, input credit_t exp, input string what);
		if (got !== exp) begin
			$display("error %0t: %s credit got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic compare_slv(input slv_req_t got, input slv_req_t exp, input string what);
		slv_req_t g;
		g = got;
		// Reads carry no write data
		if (!exp.we) begin
			g.dat = exp.dat;
			g.sel = exp.sel;
		end
		if (g !== exp) begin
			$display("error %0t: %s slave access got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic compare_word(input logic [15:0] got, input logic [15:0] exp,
		input string what);
		if (got !== exp) begin
			$display("error %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("error %0t: %s count got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic send_tlp(input int c);
		int w;
		for (w = 0; w < tlp_len[c]; w++) begin
			@(negedge pcie_clk);
			rx_st_i <= (w == 0);
			rx_end_i <= (w == tlp_len[c] - 1);
			rx_data_i <= tlp_words[c][w];
			rx_bar_hit_i <= tlp_bar[c];
		end
		@(negedge pcie_clk);
		rx_st_i <= 1'b0;
		rx_end_i <= 1'b0;
	endtask

	task automatic run_case(input int c);
		int  cycles;
		bit  done;
		int  n_cr;
		int  k;
		int  rdy_delay;
		n_cr = (exp_credit[c] !== '0) ? 1 : 0;
		cr_q.delete();
		slv_q.delete();
		tx_q.delete();
		req_cnt = 0;
		rdy_delay = $random(seed) & 32'h7;
		send_tlp(c);
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < 100) begin
			@(negedge pcie_clk);
			// Hold off the grant for a random number of cycles
			if (tx_req_o && !tx_rdy_i) begin
				if (rdy_delay == 0)
					tx_rdy_i <= 1'b1;
				else
					rdy_delay--;
			end else if (!tx_req_o && tx_rdy_i) begin
				tx_rdy_i <= 1'b0;
			end
			@(posedge pcie_clk);
			cycles++;
			done = cycles >= 12 && cr_q.size() >= n_cr && slv_q.size() >= exp_slv_n[c]
				&& tx_q.size() >= exp_tx_n[c];
		end
		if (!done) begin
			$display("timeout waiting for the results of case %0d", c);
			timeouts++;
		end
		@(negedge pcie_clk);
		tx_rdy_i <= 1'b0;
		@(posedge pcie_clk);
		compare_count(cr_q.size(), n_cr, $sformatf("case %0d credit", c));
		if (cr_q.size() > 0 && n_cr > 0)
			compare_credit(cr_q[0], exp_credit[c], $sformatf("case %0d", c));
		compare_count(slv_q.size(), exp_slv_n[c], $sformatf("case %0d slave", c));
		for (k = 0; k < slv_q.size() && k < exp_slv_n[c]; k++)
			compare_slv(slv_q[k], exp_slv[c][k], $sformatf("case %0d access %0d", c, k));
		compare_count(tx_q.size(), exp_tx_n[c], $sformatf("case %0d tx word", c));
		compare_count(req_cnt, exp_req_n[c], $sformatf("case %0d tx request", c));
		for (k = 0; k < tx_q.size() && k < exp_tx_n[c]; k++) begin
			compare_word(tx_q[k][15:0], exp_tx[c][k][15:0],
				$sformatf("case %0d tx word %0d", c, k));
			if (tx_q[k][16] !== exp_tx[c][k][16]) begin
				$display("error %0t: case %0d tx_end_o wrong on word %0d", $time, c, k);
				errors++;
			end
		end
		for (k = 0; k < mem_chk_n[c]; k++)
			compare_word(slv_mem[mem_chk_adr[c][k]], mem_chk_val[c][k],
				$sformatf("case %0d memory %h", c, mem_chk_adr[c][k]));
	endtask

	task automatic check_idle_outputs(input string what);
		compare_credit(credit_o, '0, what);
		if (tx_req_o !== 1'b0 || slv_o.ce !== 1'b0) begin
			$display("error %0t: %s tx_req_o or slave ce active", $time, what);
			errors++;
		end
	endtask

	initial begin
		#20000;
		$display("simulation limit reached before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int i;
		sys_rst = 1'b1;
		rx_bar_hit_i = '0;
		rx_st_i = 1'b0;
		rx_end_i = 1'b0;
		rx_data_i = '0;
		cpl_id_i = '{bus: 8'h03, device: 5'h04, func: 3'h1};
		tx_rdy_i = 1'b0;
		slv_dat_i = '0;
		for (i = 0; i < 1024; i++)
			slv_mem[i] = fill_pattern(10'(i));
		fill_case_table();

		// ------------------------------------------------------------
		// Reset, outputs idle during and just after
		// ------------------------------------------------------------
		for (i = 0; i < 3; i++) begin
			@(negedge pcie_clk);
			check_idle_outputs("in reset");
		end
		sys_rst <= 1'b0;
		for (i = 0; i < 2; i++) begin
			@(negedge pcie_clk);
			check_idle_outputs("after reset");
		end
		@(posedge pcie_clk);

		for (i = 0; i < N_CASES; i++)
			run_case(i);

		$display("run complete: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+testbench
logic/tlp_pkg.sv
logic/tlp_rx_parser.sv
logic/rx_credit_release.sv
logic/slave_sequencer.sv
logic/cpl_transmitter.sv
logic/pcie_tlp_top.sv
testbench/tb_pcie_tlp.sv
